//--- pba_pkg.sv
////////////////////////////////////////////////////////////////////////////
// PCI bus access shared definitions
// Bus widths, PCI command codes, core status bits, FIFO sizing,
// the pending request record and the local master state encoding
////////////////////////////////////////////////////////////////////////////
package pba_pkg;

   // Widths that carry a meaning on the local side
   typedef logic [31:0] pci_data_t;
   typedef logic [31:0] pci_addr_t;
   typedef logic [3:0]  pci_cbe_t;
   typedef logic [7:0]  burst_t;
   typedef logic [9:0]  lm_tsr_t;

   // PCI bus commands driven in the address phase
   localparam pci_cbe_t PCI_CMD_MEM_RD = 4'h6;
   localparam pci_cbe_t PCI_CMD_MEM_WR = 4'h7;

   // Bit positions in the core transfer status vector
   localparam int TSR_DATA_PHASE = 3;
   localparam int TSR_DISC_WD    = 6;
   localparam int TSR_DISC_WOD   = 7;
   localparam int TSR_MSTR_ABORT = 9;

   // Write data buffer sizing, depth is a power of two
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = 4;

   // One pending request from the Avalon side
   typedef struct packed {
      logic      wr;
      pci_addr_t addr;
      burst_t    burst;
   } pba_req_t;

   // Local master controller states
   typedef enum logic [1:0] {
      LB_IDLE,
      LB_REQ,
      LB_WRITE,
      LB_READ
   } lb_state_t;

endpackage

//--- pba_req_capture.sv
////////////////////////////////////////////////////////////////////////////
// Avalon request capture
// Holds one request until the local master takes it and steers
// the write beats of that burst into the write data buffer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pba_req_capture (
   input  logic               pci_clk_i,
   input  logic               pci_rstn_i,
   input  logic               avl_wr_req_i,
   input  logic               avl_rd_req_i,
   input  pba_pkg::pci_addr_t avl_addr_i,
   input  pba_pkg::burst_t    avl_burst_i,
   input  logic               avl_wdata_valid_i,
   input  pba_pkg::pci_data_t avl_wdata_i,
   input  logic               req_take_i,
   input  logic               busy_i,
   output pba_pkg::pba_req_t  req_o,
   output logic               req_valid_o,
   output logic               fifo_push_o,
   output pba_pkg::pci_data_t fifo_wdata_o,
   output logic               busy_o
);

   logic            accept;
   logic            taken_q;
   pba_pkg::burst_t wr_left_q;

   assign accept = (avl_wr_req_i | avl_rd_req_i) & ~busy_o;

   // Beats past the burst length fall on the floor
   assign fifo_push_o  = avl_wdata_valid_i & (accept ? avl_wr_req_i : (wr_left_q != '0));
   assign fifo_wdata_o = avl_wdata_i;

   // Request record, write wins if both strobes come together
   always_ff @(posedge pci_clk_i)
   begin
      if (accept)
      begin
         req_o.wr    <= avl_wr_req_i;
         req_o.addr  <= avl_addr_i;
         req_o.burst <= avl_burst_i;
      end
   end

   // Pending flag and busy span
   always_ff @(posedge pci_clk_i or negedge pci_rstn_i)
   begin
      if (!pci_rstn_i)
      begin
         req_valid_o <= 1'b0;
         busy_o      <= 1'b0;
         taken_q     <= 1'b0;
      end
      else if (accept)
      begin
         req_valid_o <= 1'b1;
         busy_o      <= 1'b1;
         taken_q     <= 1'b0;
      end
      else
      begin
         if (req_take_i)
         begin
            req_valid_o <= 1'b0;
            taken_q     <= 1'b1;
         end
         // Controller went idle again, burst is done
         if (taken_q && !busy_i)
         begin
            busy_o  <= 1'b0;
            taken_q <= 1'b0;
         end
      end
   end

   // Write beats still expected for the current burst
   always_ff @(posedge pci_clk_i or negedge pci_rstn_i)
   begin
      if (!pci_rstn_i)
         wr_left_q <= '0;
      else if (accept)
         wr_left_q <= avl_wr_req_i ?
                      avl_burst_i - pba_pkg::burst_t'(avl_wdata_valid_i) : '0;
      else if (fifo_push_o)
         wr_left_q <= wr_left_q - 8'd1;
   end

   a_burst_nonzero: assert property (@(posedge pci_clk_i) disable iff (!pci_rstn_i)
      (avl_wr_req_i || avl_rd_req_i) |-> (avl_burst_i != '0));

   // Requester waits until the previous burst has fully completed
   a_no_req_while_busy: assert property (@(posedge pci_clk_i) disable iff (!pci_rstn_i)
      (avl_wr_req_i || avl_rd_req_i) |-> !busy_o);

endmodule

//--- pba_wr_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Write data FIFO
// Synchronous first-word-fall-through buffer between the Avalon
// write beats and the PCI local master
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pba_wr_fifo (
   input  logic                           pci_clk_i,
   input  logic                           pci_rstn_i,
   input  logic                           push_i,
   input  pba_pkg::pci_data_t             wdata_i,
   input  logic                           pop_i,
   output pba_pkg::pci_data_t             rdata_o,
   output logic [pba_pkg::FIFO_PTR_W:0]   used_o
);

   pba_pkg::pci_data_t               mem_q [pba_pkg::FIFO_DEPTH];
   logic [pba_pkg::FIFO_PTR_W-1:0]   wr_ptr_q;
   logic [pba_pkg::FIFO_PTR_W-1:0]   rd_ptr_q;
   logic [pba_pkg::FIFO_PTR_W:0]     used_q;
   logic                             full;
   logic                             empty;
   logic                             do_push;
   logic                             do_pop;

   assign empty   = (used_q == '0);
   assign full    = (used_q == (pba_pkg::FIFO_PTR_W+1)'(pba_pkg::FIFO_DEPTH));
   assign do_push = push_i & ~full;
   assign do_pop  = pop_i & ~empty;

   // Head word visible without a read cycle
   assign rdata_o = mem_q[rd_ptr_q];
   assign used_o  = used_q;

   always_ff @(posedge pci_clk_i)
   begin
      if (do_push)
         mem_q[wr_ptr_q] <= wdata_i;
   end

   // Pointers wrap on their own since depth is a power of two
   always_ff @(posedge pci_clk_i or negedge pci_rstn_i)
   begin
      if (!pci_rstn_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         used_q   <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (do_pop)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({do_push, do_pop})
            2'b10:   used_q <= used_q + 1'b1;
            2'b01:   used_q <= used_q - 1'b1;
            default: used_q <= used_q;
         endcase
      end
   end

   // Controller only pops words it has been told are there
   a_no_pop_empty: assert property (@(posedge pci_clk_i) disable iff (!pci_rstn_i)
      pop_i |-> !empty);

   // Overflow means an Avalon write beat was lost
   a_no_push_full: assert property (@(posedge pci_clk_i) disable iff (!pci_rstn_i)
      push_i |-> !full);

endmodule

//--- pba_loc_master.sv
////////////////////////////////////////////////////////////////////////////
// PCI local master controller
// Runs the request, address and data phases of the core's local master
// port, counts the burst, resumes after target disconnects and closes
// a master-aborted read with all-ones data
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pba_loc_master (
   input  logic                           pci_clk_i,
   input  logic                           pci_rstn_i,
   input  logic [6:0]                     cmd_reg_i,
   // Pending request
   input  pba_pkg::pba_req_t              req_i,
   input  logic                           req_valid_i,
   output logic                           req_take_o,
   // Write data buffer
   input  pba_pkg::pci_data_t             fifo_rdata_i,
   input  logic [pba_pkg::FIFO_PTR_W:0]   fifo_used_i,
   output logic                           fifo_pop_o,
   // PCI core local master port
   input  logic                           lm_adr_ackn_i,
   input  logic                           lm_ackn_i,
   input  logic                           lm_dxfrn_i,
   input  pba_pkg::lm_tsr_t               lm_tsr_i,
   input  pba_pkg::pci_data_t             l_dato_i,
   output logic                           lm_req32n_o,
   output logic                           lm_rdyn_o,
   output logic                           lm_lastn_o,
   output pba_pkg::pci_data_t             l_adi_o,
   output pba_pkg::pci_cbe_t              l_cben_o,
   // Read return and status
   output pba_pkg::pci_data_t             pba_readdata_o,
   output logic                           pba_readdatavalid_o,
   output logic                           busy_o
);

   pba_pkg::lb_state_t  state_q;
   pba_pkg::lb_state_t  state_d;
   pba_pkg::pba_req_t   req_q;
   pba_pkg::burst_t     burst_cnt_q;
   pba_pkg::burst_t     beats_done;
   pba_pkg::pci_addr_t  cur_addr;
   pba_pkg::pci_data_t  dout_q;
   logic                dout_v_q;
   logic                disc_stat_q;
   logic                abort_q;
   logic                master_ena;
   logic                in_req;
   logic                in_write;
   logic                in_read;
   logic                start;
   logic                wr_xfer;
   logic                abort_now;
   logic                rd_beat;
   logic                beat;
   logic                disc_stat;
   logic                disc_hit;
   logic                load;

   assign master_ena = cmd_reg_i[2];
   assign in_req     = (state_q == pba_pkg::LB_REQ);
   assign in_write   = (state_q == pba_pkg::LB_WRITE);
   assign in_read    = (state_q == pba_pkg::LB_READ);

   // A write needs its first word buffered before we go to the bus
   assign start      = (state_q == pba_pkg::LB_IDLE) & req_valid_i & master_ena &
                       (~req_i.wr | (fifo_used_i != '0));
   assign req_take_o = start;

   ////////////////////////////////////////////////////////////////////////////
   // Beat accounting
   ////////////////////////////////////////////////////////////////////////////
   assign wr_xfer   = in_write & ~lm_dxfrn_i;
   assign abort_now = in_read & (abort_q | lm_tsr_i[pba_pkg::TSR_MSTR_ABORT]);
   // After an abort one filler beat per cycle
   assign rd_beat   = in_read & (~lm_dxfrn_i | abort_now);
   assign beat      = wr_xfer | rd_beat;

   // Only a fresh disconnect counts since the core may hold the status bit
   assign disc_stat = lm_tsr_i[pba_pkg::TSR_DISC_WD] | lm_tsr_i[pba_pkg::TSR_DISC_WOD];
   assign disc_hit  = (in_write | in_read) & disc_stat & ~disc_stat_q & ~abort_now;

   assign beats_done = req_q.burst - burst_cnt_q;
   assign cur_addr   = req_q.addr + pba_pkg::pci_addr_t'({beats_done, 2'b00});

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         pba_pkg::LB_IDLE:
            if (start)
               state_d = pba_pkg::LB_REQ;
         pba_pkg::LB_REQ:
            if (!lm_adr_ackn_i)
               state_d = req_q.wr ? pba_pkg::LB_WRITE : pba_pkg::LB_READ;
         pba_pkg::LB_WRITE, pba_pkg::LB_READ:
            if (beat && burst_cnt_q == 8'd1)
               state_d = pba_pkg::LB_IDLE;
            else if (disc_hit)
               state_d = pba_pkg::LB_REQ;
         default:
            state_d = pba_pkg::LB_IDLE;
      endcase
   end

   always_ff @(posedge pci_clk_i or negedge pci_rstn_i)
   begin
      if (!pci_rstn_i)
      begin
         state_q     <= pba_pkg::LB_IDLE;
         burst_cnt_q <= '0;
         abort_q     <= 1'b0;
         disc_stat_q <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         disc_stat_q <= disc_stat;
         if (start)
            burst_cnt_q <= req_i.burst;
         else if (beat)
            burst_cnt_q <= burst_cnt_q - 8'd1;
         if (start)
            abort_q <= 1'b0;
         else if (in_read && lm_tsr_i[pba_pkg::TSR_MSTR_ABORT])
            abort_q <= 1'b1;
      end
   end

   always_ff @(posedge pci_clk_i)
   begin
      if (start)
         req_q <= req_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Write data staging
   ////////////////////////////////////////////////////////////////////////////
   // dout_q is the word offered to the core
   // It survives a disconnect and is offered again after the re-request
   assign load = req_q.wr & (in_req | in_write) & (fifo_used_i != '0) &
                 (dout_v_q ? (wr_xfer & (burst_cnt_q > 8'd1)) : (burst_cnt_q != '0));
   assign fifo_pop_o = load;

   always_ff @(posedge pci_clk_i or negedge pci_rstn_i)
   begin
      if (!pci_rstn_i)
         dout_v_q <= 1'b0;
      else if (load)
         dout_v_q <= 1'b1;
      else if (wr_xfer)
         dout_v_q <= 1'b0;
   end

   always_ff @(posedge pci_clk_i)
   begin
      if (load)
         dout_q <= fifo_rdata_i;
   end

   // Core side outputs
   assign lm_req32n_o = ~(in_req & master_ena);
   assign lm_rdyn_o   = ~((in_write & dout_v_q) | in_read);
   assign lm_lastn_o  = ~((in_write | in_read) & (burst_cnt_q == 8'd1));
   assign l_adi_o     = in_req ? cur_addr : dout_q;
   // All byte lanes enabled in the data phase
   assign l_cben_o    = in_req ? (req_q.wr ? pba_pkg::PCI_CMD_MEM_WR : pba_pkg::PCI_CMD_MEM_RD)
                               : 4'h0;

   assign pba_readdata_o      = abort_now ? '1 : l_dato_i;
   assign pba_readdatavalid_o = rd_beat;
   assign busy_o              = (state_q != pba_pkg::LB_IDLE);

   // A zero count in a transfer state would run past the last beat flag
   a_lastn_reachable: assert property (@(posedge pci_clk_i) disable iff (!pci_rstn_i)
      (in_write || in_read) |-> (burst_cnt_q != '0));

   // Core only moves data while it reports a data phase
   a_xfer_in_data_phase: assert property (@(posedge pci_clk_i) disable iff (!pci_rstn_i)
      ((in_write || in_read) && !lm_dxfrn_i) |->
         (!lm_ackn_i && lm_tsr_i[pba_pkg::TSR_DATA_PHASE]));

endmodule

//--- pba_top.sv
////////////////////////////////////////////////////////////////////////////
// PCI bus access top level
// Request capture, write data FIFO and local master controller
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pba_top (
   input  logic               pci_clk_i,
   input  logic               pci_rstn_i,
   input  logic [6:0]         cmd_reg_i,
   // Avalon request side
   input  logic               avl_wr_req_i,
   input  logic               avl_rd_req_i,
   input  pba_pkg::pci_addr_t avl_addr_i,
   input  pba_pkg::burst_t    avl_burst_i,
   input  logic               avl_wdata_valid_i,
   input  pba_pkg::pci_data_t avl_wdata_i,
   output logic               busy_o,
   // PCI core local master port
   input  logic               lm_adr_ackn_i,
   input  logic               lm_ackn_i,
   input  logic               lm_dxfrn_i,
   input  pba_pkg::lm_tsr_t   lm_tsr_i,
   input  pba_pkg::pci_data_t l_dato_i,
   output logic               lm_req32n_o,
   output logic               lm_rdyn_o,
   output logic               lm_lastn_o,
   output pba_pkg::pci_data_t l_adi_o,
   output pba_pkg::pci_cbe_t  l_cben_o,
   // Read return
   output pba_pkg::pci_data_t pba_readdata_o,
   output logic               pba_readdatavalid_o
);

   pba_pkg::pba_req_t               req;
   logic                            req_valid;
   logic                            req_take;
   logic                            lm_busy;
   logic                            fifo_push;
   pba_pkg::pci_data_t              fifo_wdata;
   logic                            fifo_pop;
   pba_pkg::pci_data_t              fifo_rdata;
   logic [pba_pkg::FIFO_PTR_W:0]    fifo_used;

   pba_req_capture pba_req_capture_i (
      .pci_clk_i(pci_clk_i), .pci_rstn_i(pci_rstn_i),
      .avl_wr_req_i(avl_wr_req_i), .avl_rd_req_i(avl_rd_req_i),
      .avl_addr_i(avl_addr_i), .avl_burst_i(avl_burst_i),
      .avl_wdata_valid_i(avl_wdata_valid_i), .avl_wdata_i(avl_wdata_i),
      .req_take_i(req_take), .busy_i(lm_busy),
      .req_o(req), .req_valid_o(req_valid),
      .fifo_push_o(fifo_push), .fifo_wdata_o(fifo_wdata), .busy_o(busy_o)
   );

   pba_wr_fifo pba_wr_fifo_i (
      .pci_clk_i(pci_clk_i), .pci_rstn_i(pci_rstn_i),
      .push_i(fifo_push), .wdata_i(fifo_wdata),
      .pop_i(fifo_pop), .rdata_o(fifo_rdata), .used_o(fifo_used)
   );

   pba_loc_master pba_loc_master_i (
      .pci_clk_i(pci_clk_i), .pci_rstn_i(pci_rstn_i), .cmd_reg_i(cmd_reg_i),
      .req_i(req), .req_valid_i(req_valid), .req_take_o(req_take),
      .fifo_rdata_i(fifo_rdata), .fifo_used_i(fifo_used), .fifo_pop_o(fifo_pop),
      .lm_adr_ackn_i(lm_adr_ackn_i), .lm_ackn_i(lm_ackn_i),
      .lm_dxfrn_i(lm_dxfrn_i), .lm_tsr_i(lm_tsr_i), .l_dato_i(l_dato_i),
      .lm_req32n_o(lm_req32n_o), .lm_rdyn_o(lm_rdyn_o), .lm_lastn_o(lm_lastn_o),
      .l_adi_o(l_adi_o), .l_cben_o(l_cben_o),
      .pba_readdata_o(pba_readdata_o), .pba_readdatavalid_o(pba_readdatavalid_o),
      .busy_o(lm_busy)
   );

endmodule

//--- tb_pba_top.sv
////////////////////////////////////////////////////////////////////////////
// PCI bus access testbench
// Runs Avalon requests from a pattern file against a behavioral PCI core
// local master model that has a word memory behind it
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_pba_top;

   localparam int ENA_HOLD     = 20;
   localparam int CYC_PER_TEST = 2000;
   localparam int MEM_WORDS    = 256;

   // One pattern line without its name
   typedef struct packed {
      pba_pkg::pci_cbe_t  cmd;
      pba_pkg::pci_addr_t addr;
      pba_pkg::burst_t    burst;
      logic [7:0]         point;
      logic               abort;
      logic [7:0]         waits;
      logic [7:0]         skip;
   } pattern_t;

   logic               pci_clk;
   logic               pci_rstn;
   logic [6:0]         cmd_reg;
   logic               avl_wr_req;
   logic               avl_rd_req;
   pba_pkg::pci_addr_t avl_addr;
   pba_pkg::burst_t    avl_burst;
   logic               avl_wdata_valid;
   pba_pkg::pci_data_t avl_wdata;
   logic               busy;
   logic               lm_adr_ackn;
   logic               lm_ackn;
   logic               lm_dxfrn;
   pba_pkg::lm_tsr_t   lm_tsr;
   pba_pkg::pci_data_t l_dato;
   logic               lm_req32n;
   logic               lm_rdyn;
   logic               lm_lastn;
   pba_pkg::pci_data_t l_adi;
   pba_pkg::pci_cbe_t  l_cben;
   pba_pkg::pci_data_t rd_data;
   logic               rd_valid;

   pattern_t           tests [$];
   string              names [$];
   pattern_t           cur;
   string              cur_name;
   int                 n_tests;
   bit                 loaded;
   int                 errors;
   int                 seed;
   int                 done;
   bit                 event_done;
   pba_pkg::pci_data_t mem_model [MEM_WORDS];
   pba_pkg::pci_data_t ref_mem [MEM_WORDS];
   pba_pkg::pci_addr_t adr_log [$];
   pba_pkg::pci_cbe_t  cmd_log [$];
   pba_pkg::pci_data_t rd_q [$];

   pba_top pba_top_i (
      .pci_clk_i(pci_clk), .pci_rstn_i(pci_rstn), .cmd_reg_i(cmd_reg),
      .avl_wr_req_i(avl_wr_req), .avl_rd_req_i(avl_rd_req),
      .avl_addr_i(avl_addr), .avl_burst_i(avl_burst),
      .avl_wdata_valid_i(avl_wdata_valid), .avl_wdata_i(avl_wdata), .busy_o(busy),
      .lm_adr_ackn_i(lm_adr_ackn), .lm_ackn_i(lm_ackn), .lm_dxfrn_i(lm_dxfrn),
      .lm_tsr_i(lm_tsr), .l_dato_i(l_dato),
      .lm_req32n_o(lm_req32n), .lm_rdyn_o(lm_rdyn), .lm_lastn_o(lm_lastn),
      .l_adi_o(l_adi), .l_cben_o(l_cben),
      .pba_readdata_o(rd_data), .pba_readdatavalid_o(rd_valid)
   );

   initial
   begin
      pci_clk = 1'b0;
      forever #5 pci_clk = ~pci_clk;
   end

   // Memory fill built from every bit of the word index
   function automatic pba_pkg::pci_data_t fill_word(input int idx);
      return {8'hc5, ~idx[7:0], idx[7:0], 8'h3a};
   endfunction

   function automatic int word_idx(input pba_pkg::pci_addr_t a, input int k);
      return (int'(a >> 2) + k) % MEM_WORDS;
   endfunction

   task automatic log_mismatch(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
      errors++;
      $display("Error %s %s: expected %h actual %h", cur_name, what, exp, act);
   endtask

   task automatic log_failure(input string what);
      errors++;
      $display("Failure in %s: %s", cur_name, what);
   endtask

   task automatic load_patterns();
      int       fd;
      int       n;
      int       v [7];
      string    line;
      string    nm;
      pattern_t p;
      fd = $fopen("pba_patterns.txt", "r");
      if (fd == 0)
      begin
         log_failure("cannot open pba_patterns.txt");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         n = $fgets(line, fd);
         // Comment and blank lines
         if (n < 2 || line.getc(0) == "#")
            continue;
         n = $sscanf(line, "%s %h %h %d %d %d %d %d", nm, v[0], v[1], v[2], v[3], v[4],
                     v[5], v[6]);
         if (n != 8)
         begin
            log_failure({"malformed pattern line: ", line});
            continue;
         end
         p.cmd   = v[0][3:0];
         p.addr  = v[1];
         p.burst = v[2][7:0];
         p.point = v[3][7:0];
         p.abort = v[4][0];
         p.waits = v[5][7:0];
         p.skip  = v[6][7:0];
         tests.push_back(p);
         names.push_back(nm);
      end
      $fclose(fd);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // PCI core responder
   ////////////////////////////////////////////////////////////////////////////
   initial
   begin : core_model
      pba_pkg::pci_addr_t base;
      bit                 is_wr;
      bit                 closing;
      logic               rdy_seen;
      logic               exp_last;
      int                 k;
      int                 wait_cnt;
      @(posedge pci_rstn);
      forever
      begin
         @(negedge pci_clk);
         if (!lm_req32n)
         begin
            @(posedge pci_clk);
            #1 lm_adr_ackn = 1'b0;
            @(negedge pci_clk);
            base  = l_adi;
            is_wr = (l_cben == pba_pkg::PCI_CMD_MEM_WR);
            adr_log.push_back(l_adi);
            cmd_log.push_back(l_cben);
            @(posedge pci_clk);
            #1;
            lm_adr_ackn = 1'b1;
            lm_ackn     = 1'b0;
            lm_tsr      = '0;
            lm_tsr[pba_pkg::TSR_DATA_PHASE] = 1'b1;
            k        = 0;
            wait_cnt = 0;
            closing  = 1'b0;
            while (1)
            begin
               @(negedge pci_clk);
               rdy_seen = !lm_rdyn;
               if (!lm_dxfrn)
               begin
                  exp_last = (done == int'(cur.burst) - 1) ? 1'b0 : 1'b1;
                  if (lm_lastn !== exp_last)
                     log_mismatch("last beat flag", 32'(exp_last), 32'(lm_lastn));
                  if (is_wr)
                     mem_model[word_idx(base, k)] = l_adi;
                  k++;
                  done++;
               end
               if (closing || done == int'(cur.burst))
                  break;
               @(posedge pci_clk);
               #1;
               lm_dxfrn = 1'b1;
               if (!event_done && done == int'(cur.point))
               begin
                  // Disconnect without data, or master abort on a read
                  event_done = 1'b1;
                  closing    = 1'b1;
                  if (cur.abort)
                     lm_tsr[pba_pkg::TSR_MSTR_ABORT] = 1'b1;
                  else
                     lm_tsr[pba_pkg::TSR_DISC_WOD] = 1'b1;
               end
               else if (wait_cnt < int'(cur.waits))
                  wait_cnt++;
               else if (!is_wr || rdy_seen)
               begin
                  wait_cnt = 0;
                  lm_dxfrn = 1'b0;
                  l_dato   = mem_model[word_idx(base, k)];
               end
            end
            @(posedge pci_clk);
            #1;
            lm_dxfrn = 1'b1;
            lm_ackn  = 1'b1;
            lm_tsr   = '0;
         end
      end
   end

   always @(negedge pci_clk)
   begin
      if (pci_rstn && rd_valid)
         rd_q.push_back(rd_data);
   end

   ////////////////////////////////////////////////////////////////////////////
   // One transaction from the pattern table
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_test(input int t);
      pba_pkg::pci_data_t wdata [$];
      pba_pkg::pci_addr_t exp_addr;
      pba_pkg::pci_data_t exp_data;
      bit                 is_wr;
      bit                 saw_req;
      int                 phases;
      int                 k;
      cur        = tests[t];
      cur_name   = names[t];
      is_wr      = (cur.cmd == pba_pkg::PCI_CMD_MEM_WR);
      phases     = (int'(cur.point) < int'(cur.burst) && !cur.abort) ? 2 : 1;
      done       = 0;
      event_done = 1'b0;
      adr_log.delete();
      cmd_log.delete();
      rd_q.delete();
      // Skip column moves the start point in the random stream
      repeat (cur.skip)
         exp_data = $random(seed);
      for (k = 0; k < int'(cur.burst); k++)
         wdata.push_back($random(seed));
      if (is_wr)
         for (k = 0; k < int'(cur.burst); k++)
            ref_mem[word_idx(cur.addr, k)] = wdata[k];

      @(posedge pci_clk);
      #1;
      avl_addr        = cur.addr;
      avl_burst       = cur.burst;
      avl_wr_req      = is_wr;
      avl_rd_req      = !is_wr;
      avl_wdata_valid = is_wr;
      avl_wdata       = wdata[0];
      for (k = 1; k < int'(cur.burst) && is_wr; k++)
      begin
         @(posedge pci_clk);
         #1;
         avl_wr_req = 1'b0;
         avl_wdata  = wdata[k];
      end
      @(posedge pci_clk);
      #1;
      avl_wr_req      = 1'b0;
      avl_rd_req      = 1'b0;
      avl_wdata_valid = 1'b0;

      // First request waits for the master enable bit
      if (t == 0)
      begin
         saw_req = 1'b0;
         repeat (ENA_HOLD)
         begin
            @(negedge pci_clk);
            if (!lm_req32n)
               saw_req = 1'b1;
         end
         if (saw_req)
            log_failure("bus requested while master enable was off");
         @(posedge pci_clk);
         #1 cmd_reg = 7'h06;
      end

      @(negedge pci_clk);
      if (!busy)
         log_failure("busy did not rise after the request");
      while (busy)
         @(negedge pci_clk);

      if (adr_log.size() != phases)
         log_mismatch("address phases", phases, adr_log.size());
      else
      begin
         if (adr_log[0] !== cur.addr)
            log_mismatch("address", cur.addr, adr_log[0]);
         if (cmd_log[0] !== cur.cmd)
            log_mismatch("command", 32'(cur.cmd), 32'(cmd_log[0]));
         if (phases == 2)
         begin
            exp_addr = cur.addr + pba_pkg::pci_addr_t'(cur.point) * 4;
            if (adr_log[1] !== exp_addr)
               log_mismatch("resume address", exp_addr, adr_log[1]);
            if (cmd_log[1] !== cur.cmd)
               log_mismatch("resume command", 32'(cur.cmd), 32'(cmd_log[1]));
         end
      end
      if (is_wr)
      begin
         if (done != int'(cur.burst))
            log_mismatch("write beats", 32'(cur.burst), done);
         for (k = 0; k < int'(cur.burst); k++)
            if (mem_model[word_idx(cur.addr, k)] !== ref_mem[word_idx(cur.addr, k)])
               log_mismatch($sformatf("memory word %0d", k), ref_mem[word_idx(cur.addr, k)],
                            mem_model[word_idx(cur.addr, k)]);
      end
      else if (rd_q.size() != int'(cur.burst))
         log_mismatch("read beats", 32'(cur.burst), rd_q.size());
      else
         for (k = 0; k < int'(cur.burst); k++)
         begin
            // Beats from the abort on come back as all ones
            exp_data = (cur.abort && k >= int'(cur.point)) ? '1 :
                       ref_mem[word_idx(cur.addr, k)];
            if (rd_q[k] !== exp_data)
               log_mismatch($sformatf("read beat %0d", k), exp_data, rd_q[k]);
         end
   endtask

   initial
   begin : watchdog
      wait (loaded);
      repeat ((n_tests + 1) * CYC_PER_TEST)
         @(posedge pci_clk);
      $display("Watchdog expired, the DUT stopped responding during %s", cur_name);
      $display("test failed");
      $finish;
   end

   initial
   begin : main_flow
      int i;
      pci_rstn        = 1'b0;
      cmd_reg         = '0;
      avl_wr_req      = 1'b0;
      avl_rd_req      = 1'b0;
      avl_addr        = '0;
      avl_burst       = '0;
      avl_wdata_valid = 1'b0;
      avl_wdata       = '0;
      lm_adr_ackn     = 1'b1;
      lm_ackn         = 1'b1;
      lm_dxfrn        = 1'b1;
      lm_tsr          = '0;
      l_dato          = '0;
      errors          = 0;
      seed            = 32;
      done            = 0;
      event_done      = 1'b0;
      cur             = '0;
      cur_name        = "reset";
      for (i = 0; i < MEM_WORDS; i++)
      begin
         mem_model[i] = fill_word(i);
         ref_mem[i]   = fill_word(i);
      end
      load_patterns();
      n_tests = tests.size();
      loaded  = 1'b1;
      repeat (16)
         @(posedge pci_clk);
      #1 pci_rstn = 1'b1;
      @(negedge pci_clk);
      if ({lm_req32n, lm_rdyn, lm_lastn} !== 3'b111)
         log_mismatch("idle strobes", 32'h7, 32'({lm_req32n, lm_rdyn, lm_lastn}));
      if ({busy, rd_valid} !== 2'b00)
         log_mismatch("busy and read valid", 32'h0, 32'({busy, rd_valid}));
      if (n_tests == 0)
         log_failure("no pattern lines were read");
      for (i = 0; i < n_tests; i++)
         run_test(i);
      repeat (4)
         @(posedge pci_clk);
      $display("Errors: %0d in %0d tests", errors, n_tests);
      if (errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

//--- pba_patterns.txt
# name cmd(hex, 7 write 6 read) addr(hex) burst point abort waits skip
# point = beats before a disconnect or abort (99 none), skip = random words dropped first
wr_single      7 00000040  1 99 0 0 0
rd_single      6 00000040  1 99 0 0 0
wr_burst4      7 00000100  4 99 0 0 3
rd_burst4      6 00000100  4 99 0 0 0
wr_burst16     7 00000200 16 99 0 1 0
rd_burst16     6 00000200 16 99 0 1 0
wr_disc3       7 00000300  8  3 0 0 5
rd_disc3       6 00000300  8  3 0 0 0
wr_disc0       7 00000080  4  0 0 2 1
rd_disc0       6 00000080  4  0 0 2 0
rd_disc5_wait  6 00000200 12  5 0 3 0
rd_abort2      6 00000100  6  2 1 0 0
rd_abort0      6 00000040  3  0 1 1 0
wr_single_top  7 000003f0  1 99 0 3 2
rd_fill        6 00000380  4 99 0 0 0
rd_single_top  6 000003f0  1 99 0 0 0

//--- pba_top.f
pba_pkg.sv
pba_req_capture.sv
pba_wr_fifo.sv
pba_loc_master.sv
pba_top.sv
tb_pba_top.sv

//--- Makefile
# Verilator build and run for the PCI bus access block
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_pba_top
FILELIST  = pba_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
